/* ccu.f */
+incdir+hdl
hdl/ccu_pkg.sv
hdl/isa_loader.sv
hdl/cfg_dispatch.sv
hdl/cfg_channel.sv
hdl/ccu_top.sv
tb/ccu_clkgen.sv
tb/ccu_asserts.sv
tb/ccu_tb.sv

/* Bender.yml */
package:
  name: ccu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ccu_pkg.sv
      - hdl/isa_loader.sv
      - hdl/cfg_dispatch.sv
      - hdl/cfg_channel.sv
      - hdl/ccu_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/ccu_clkgen.sv
      - tb/ccu_asserts.sv
      - tb/ccu_tb.sv

/* tb/ccu_tb.sv */
// CCU testbench
// Random networks from a fixed seed: a header, shuffled engine words and
// a filler word, sent as beats with random gaps against random engine
// ready. One queue per channel holds the expected configurations.
`include "ccu_params.svh"

module ccu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          NUM_CH       = `CCU_NUM_CH;
    localparam int          CFG_W        = `CCU_NIP_WIDTH + `CCU_ARG_WIDTH;
    localparam int          NUM_RUNS     = 8;
    localparam int          BP_RUN       = 3;       // Channel 1 held off
    localparam int          ZERO_RUN     = 5;       // Header with no layers
    localparam int          STALL_CYCLES = 200;
    localparam int          MIN_LOW_RUN  = 50;      // in_ready_o low streak under stall
    localparam logic [31:0] SEED         = 32'hc088_b8f7;

    logic                                    clk;
    logic                                    rst_n;
    logic                                    start;
    logic [`CCU_IN_WIDTH-1:0]                in_data;
    logic                                    in_valid;
    logic                                    in_ready;
    logic [NUM_CH-1:0]                       cfg_ready;
    logic [NUM_CH-1:0]                       cfg_valid;
    logic [NUM_CH-1:0][`CCU_NIP_WIDTH-1:0]   cfg_nip;
    logic [NUM_CH-1:0][`CCU_ARG_WIDTH-1:0]   cfg_arg;
    logic [7:0]                              net_mode;
    logic                                    net_done;
    logic                                    net_busy;

    // Reference model state
    logic [CFG_W-1:0]  exp_q [NUM_CH][$];
    int                hs_cnt [NUM_CH];
    int                exp_layers;
    logic [7:0]        exp_mode;
    int                run_layers [NUM_RUNS];

    int                err_cnt;
    int                done_cnt;
    int                stall_cnt;
    int                low_run;
    int                low_max;
    int                cycle_cnt;
    int                cycle_limit;

    ccu_clkgen i_clkgen (.clk_o(clk));

    ccu_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start),
        .in_data_i   (in_data),
        .in_valid_i  (in_valid),
        .cfg_ready_i (cfg_ready),
        .in_ready_o  (in_ready),
        .cfg_valid_o (cfg_valid),
        .cfg_nip_o   (cfg_nip),
        .cfg_arg_o   (cfg_arg),
        .net_mode_o  (net_mode),
        .net_done_o  (net_done),
        .net_busy_o  (net_busy)
    );

    // ==============================
    // Checks
    // ==============================
    task automatic check_handshake(input int ch);
        logic [CFG_W-1:0] got;
        logic [CFG_W-1:0] exp;
        got = {cfg_nip[ch], cfg_arg[ch]};
        hs_cnt[ch]++;
        if (exp_q[ch].size() == 0) begin
            $display("Channel %0d delivered an unexpected configuration at %0t", ch, $time);
            err_cnt++;
        end else begin
            exp = exp_q[ch].pop_front();
            if (got !== exp) begin
                $display("[FAIL] %0t ch%0d nip/arg %h, expected %h", $time, ch, got, exp);
                err_cnt++;
            end
        end
        if (!net_busy || net_mode !== exp_mode) begin
            $display("[FAIL] %0t net_mode_o %h busy %b, expected %h busy 1",
                     $time, net_mode, net_busy, exp_mode);
            err_cnt++;
        end
    endtask

    task automatic check_run_end();
        done_cnt++;
        if (net_mode !== exp_mode) begin
            $display("[FAIL] %0t net_mode_o %h at done, expected %h", $time, net_mode, exp_mode);
            err_cnt++;
        end
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (hs_cnt[ch] != exp_layers) begin
                $display("[FAIL] %0t ch%0d made %0d handshakes, expected %0d",
                         $time, ch, hs_cnt[ch], exp_layers);
                err_cnt++;
            end
            if (exp_q[ch].size() != 0) begin
                $display("Channel %0d ended the run with %0d configurations undelivered",
                         ch, exp_q[ch].size());
                err_cnt++;
            end
        end
    endtask

    // Engine ready and output watch, all on the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            cfg_ready = '0;
            if (in_ready || cfg_valid != '0 || net_done || net_busy) begin
                $display("Outputs are not low during reset at %0t", $time);
                err_cnt++;
            end
        end else begin
            for (int ch = 0; ch < NUM_CH; ch++)
                cfg_ready[ch] = ($urandom_range(0, 3) != 0);   // Ready 3 of 4 cycles
            if (stall_cnt > 0) begin
                cfg_ready[1] = 1'b0;
                stall_cnt--;
                if (!in_ready && net_busy && !net_done) begin
                    low_run++;
                    if (low_run > low_max)
                        low_max = low_run;
                end else begin
                    low_run = 0;
                end
            end
            // Transfer happens at the next rising edge
            for (int ch = 0; ch < NUM_CH; ch++) begin
                if (cfg_valid[ch] && cfg_ready[ch])
                    check_handshake(ch);
            end
            if (net_done)
                check_run_end();
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout after %0d cycles with %0d errors so far", cycle_cnt, err_cnt);
            $display("Finished with errors");
            $finish;
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    // Builds one network, sends it and waits for its done pulse
    task automatic run_network(input int layers, input bit stall);
        logic [`CCU_WORD_WIDTH-1:0] words [$];
        logic [`CCU_NIP_WIDTH-1:0]  nip;
        logic [`CCU_ARG_WIDTH-1:0]  arg;
        logic [7:0]                 mode;
        int                         order [NUM_CH];
        int                         j;
        int                         tmp;
        int                         gap;
        int                         done_before;
        mode       = 8'($urandom_range(0, 255));
        exp_mode   = mode;
        exp_layers = layers;
        for (int ch = 0; ch < NUM_CH; ch++)
            hs_cnt[ch] = 0;
        // Header: reserved, mode, layer count, opcode
        words.push_back({32'($urandom()), mode, 16'(layers), `CCU_OPC_HDR});
        for (int l = 0; l < layers; l++) begin
            for (int c = 0; c < NUM_CH; c++)
                order[c] = c;
            for (int c = NUM_CH - 1; c > 0; c--) begin
                j        = $urandom_range(0, c);
                tmp      = order[c];
                order[c] = order[j];
                order[j] = tmp;
            end
            for (int c = 0; c < NUM_CH; c++) begin
                nip = 16'($urandom());
                arg = {8'($urandom()), 32'($urandom())};
                words.push_back({arg, nip, 8'(`CCU_OPC_ENG_BASE + order[c])});
                exp_q[order[c]].push_back({nip, arg});
            end
        end
        if (words.size() % 2 != 0)
            words.push_back({32'($urandom()), 24'($urandom()), 8'h00});   // Filler
        stall_cnt   = stall ? STALL_CYCLES : 0;
        low_run     = 0;
        low_max     = 0;
        done_before = done_cnt;

        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        for (int b = 0; b < words.size() / 2; b++) begin
            gap = $urandom_range(0, 2);
            repeat (gap) begin
                @(negedge clk);
                in_valid = 1'b0;
            end
            @(negedge clk);
            in_valid = 1'b1;
            in_data  = {words[2*b+1], words[2*b]};      // Low word first
            while (!in_ready)
                @(negedge clk);
        end
        @(negedge clk);
        in_valid = 1'b0;
        while (done_cnt == done_before)
            @(posedge clk);
    endtask

    initial begin
        int seed_val;
        int total_words;
        seed_val  = $urandom(SEED);
        rst_n     = 1'b0;
        start     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        cfg_ready = '0;
        err_cnt   = 0;
        done_cnt  = 0;
        stall_cnt = 0;
        cycle_cnt = 0;
        for (int r = 0; r < NUM_RUNS; r++)
            run_layers[r] = $urandom_range(1, 4);
        run_layers[BP_RUN]   = 4;       // 18 words, more than the RAM holds
        run_layers[ZERO_RUN] = 0;
        total_words = 0;
        for (int r = 0; r < NUM_RUNS; r++)
            total_words += 2 + 4 * run_layers[r];
        cycle_limit = 60 * total_words + 200;

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);

        for (int r = 0; r < NUM_RUNS; r++) begin
            run_network(run_layers[r], r == BP_RUN);
            if (r == BP_RUN && low_max < MIN_LOW_RUN) begin
                $display("in_ready_o did not stay low while channel 1 was stalled (%0d cycles)",
                         low_max);
                err_cnt++;
            end
        end

        repeat (20) @(posedge clk);
        if (done_cnt != NUM_RUNS) begin
            $display("[FAIL] %0t saw %0d done pulses, expected %0d", $time, done_cnt, NUM_RUNS);
            err_cnt++;
        end
        $display("Errors: %0d from checks, %0d from assertions",
                 err_cnt, i_dut.i_ccu_asserts.assert_errs);
        if (err_cnt == 0 && i_dut.i_ccu_asserts.assert_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* tb/ccu_asserts.sv */
// CCU assertions
// Done pulse, input stream gating and engine handshake stability,
// bound into the top level of the configuration control unit
`include "ccu_params.svh"

module ccu_asserts (
    input logic                                       clk,
    input logic                                       rst_n,
    input ccu_pkg::disp_state_e                       state_i,
    input logic                                       in_ready_i,
    input logic                                       net_done_i,
    input logic [`CCU_NUM_CH-1:0]                     cfg_valid_i,
    input logic [`CCU_NUM_CH-1:0]                     cfg_ready_i,
    input logic [`CCU_NUM_CH-1:0][`CCU_NIP_WIDTH-1:0] cfg_nip_i,
    input logic [`CCU_NUM_CH-1:0][`CCU_ARG_WIDTH-1:0] cfg_arg_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned assert_errs = 0;     // Read by the testbench at the end

    // ==============================
    // Run control
    // ==============================
    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        net_done_i |=> !net_done_i)
        else begin
            $error("net_done_o stayed high for more than one cycle");
            assert_errs++;
        end

    // No beat accepted while no run is active
    ready_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state_i == ccu_pkg::IDLE || state_i == ccu_pkg::DONE) |-> !in_ready_i)
        else begin
            $error("in_ready_o high outside a run");
            assert_errs++;
        end

    // ==============================
    // Engine handshakes
    // ==============================
    for (genvar g = 0; g < `CCU_NUM_CH; g++) begin : gen_hold
        cfg_hold: assert property (@(posedge clk) disable iff (!rst_n)
            (cfg_valid_i[g] && !cfg_ready_i[g]) |=>
                (cfg_valid_i[g] && $stable(cfg_nip_i[g]) && $stable(cfg_arg_i[g])))
            else begin
                $error("Channel %0d dropped or changed its configuration before ready", g);
                assert_errs++;
            end
    end

endmodule

bind ccu_top ccu_asserts i_ccu_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .state_i     (i_cfg_dispatch.state_q),
    .in_ready_i  (in_ready_o),
    .net_done_i  (net_done_o),
    .cfg_valid_i (cfg_valid_o),
    .cfg_ready_i (cfg_ready_i),
    .cfg_nip_i   (cfg_nip_o),
    .cfg_arg_i   (cfg_arg_o)
);

/* tb/ccu_clkgen.sv */
// Testbench clock generator
// Free-running clock, 10 ns period by default
module ccu_clkgen #(
    parameter int HALF_PERIOD_NS = 5
) (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;   // First rising edge after half a period
        forever begin
            #(HALF_PERIOD_NS);
            clk_o = ~clk_o;
        end
    end

endmodule

/* hdl/ccu_top.sv */
// Configuration control unit, top level
// Instruction loader, run dispatcher and one configuration channel
// per engine: systolic array, pooling, FPS and KNN
`include "ccu_params.svh"

module ccu_top (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          start_i,
    input  logic [`CCU_IN_WIDTH-1:0]                      in_data_i,
    input  logic                                          in_valid_i,
    input  logic [`CCU_NUM_CH-1:0]                        cfg_ready_i,
    output logic                                          in_ready_o,
    output logic [`CCU_NUM_CH-1:0]                        cfg_valid_o,
    output logic [`CCU_NUM_CH-1:0][`CCU_NIP_WIDTH-1:0]    cfg_nip_o,
    output logic [`CCU_NUM_CH-1:0][`CCU_ARG_WIDTH-1:0]    cfg_arg_o,
    output logic [7:0]                                    net_mode_o,
    output logic                                          net_done_o,
    output logic                                          net_busy_o
);

    logic                                       run_clear;
    logic                                       run_active;
    logic                                       rd_en;
    logic [`CCU_PTR_WIDTH-1:0]                  rd_addr;
    logic                                       rd_valid;
    ccu_pkg::isa_word_u                         rd_data;
    logic [`CCU_PTR_WIDTH-1:0]                  wr_ptr;
    logic [`CCU_LAYER_WIDTH-1:0]                num_layer;
    logic [`CCU_NUM_CH-1:0]                     grant;
    logic [`CCU_NUM_CH-1:0]                     ch_req;
    logic [`CCU_NUM_CH-1:0]                     ch_done;
    logic [`CCU_NUM_CH-1:0][`CCU_PTR_WIDTH-1:0] ch_ptr;

    isa_loader i_isa_loader (
        .clk          (clk),
        .rst_n        (rst_n),
        .run_clear_i  (run_clear),
        .run_active_i (run_active),
        .in_data_i    (in_data_i),
        .in_valid_i   (in_valid_i),
        .rd_en_i      (rd_en),
        .rd_addr_i    (rd_addr),
        .ch_ptr_i     (ch_ptr),
        .in_ready_o   (in_ready_o),
        .wr_ptr_o     (wr_ptr),
        .rd_data_o    (rd_data)
    );

    cfg_dispatch i_cfg_dispatch (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .wr_ptr_i     (wr_ptr),
        .rd_data_i    (rd_data),
        .ch_req_i     (ch_req),
        .ch_done_i    (ch_done),
        .ch_ptr_i     (ch_ptr),
        .run_clear_o  (run_clear),
        .run_active_o (run_active),
        .rd_en_o      (rd_en),
        .rd_addr_o    (rd_addr),
        .grant_o      (grant),
        .rd_valid_o   (rd_valid),
        .num_layer_o  (num_layer),
        .net_mode_o   (net_mode_o),
        .net_done_o   (net_done_o),
        .net_busy_o   (net_busy_o)
    );

    // Channel i owns opcode base plus i
    for (genvar g = 0; g < `CCU_NUM_CH; g++) begin : gen_ch
        cfg_channel #(
            .CH_OPCODE (8'(`CCU_OPC_ENG_BASE + g))
        ) i_cfg_channel (
            .clk         (clk),
            .rst_n       (rst_n),
            .clear_i     (run_clear),
            .grant_i     (grant[g]),
            .rd_valid_i  (rd_valid),
            .rd_data_i   (rd_data),
            .wr_ptr_i    (wr_ptr),
            .num_layer_i (num_layer),
            .cfg_ready_i (cfg_ready_i[g]),
            .req_o       (ch_req[g]),
            .done_o      (ch_done[g]),
            .ptr_o       (ch_ptr[g]),
            .cfg_valid_o (cfg_valid_o[g]),
            .cfg_nip_o   (cfg_nip_o[g]),
            .cfg_arg_o   (cfg_arg_o[g])
        );
    end

endmodule

/* hdl/cfg_channel.sv */
// Engine configuration channel
// Keeps one engine's read pointer into the shared instruction RAM and
// its delivered layer count. Words with its own opcode are registered
// and held under valid/ready, all other words are skipped.
`include "ccu_params.svh"

module cfg_channel #(
    parameter logic [7:0] CH_OPCODE = `CCU_OPC_ENG_BASE
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          clear_i,
    input  logic                          grant_i,
    input  logic                          rd_valid_i,
    input  ccu_pkg::isa_word_u            rd_data_i,
    input  logic [`CCU_PTR_WIDTH-1:0]     wr_ptr_i,
    input  logic [`CCU_LAYER_WIDTH-1:0]   num_layer_i,
    input  logic                          cfg_ready_i,
    output logic                          req_o,
    output logic                          done_o,
    output logic [`CCU_PTR_WIDTH-1:0]     ptr_o,
    output logic                          cfg_valid_o,
    output logic [`CCU_NIP_WIDTH-1:0]     cfg_nip_o,
    output logic [`CCU_ARG_WIDTH-1:0]     cfg_arg_o
);

    logic [`CCU_PTR_WIDTH-1:0]    ptr_q;
    logic [`CCU_LAYER_WIDTH-1:0]  cnt_q;        // Delivered layers
    logic                         valid_q;
    logic [`CCU_NIP_WIDTH-1:0]    nip_q;
    logic [`CCU_ARG_WIDTH-1:0]    arg_q;
    logic                         take;
    logic                         own;

    assign take = grant_i & rd_valid_i;           // Word inspected this cycle
    assign own  = (rd_data_i.eng.opcode == CH_OPCODE);

    // Ask only when the engine can take a new configuration right away
    assign req_o  = cfg_ready_i & ~valid_q & (cnt_q < num_layer_i) & (ptr_q != wr_ptr_i);
    assign done_o = (cnt_q == num_layer_i) & ~valid_q;

    // ==============================
    // Pointer and layer count
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q <= '0;
            cnt_q <= '0;
        end else if (clear_i) begin
            ptr_q <= '0;
            cnt_q <= '0;
        end else if (take) begin
            ptr_q <= ptr_q + 1'b1;     // Skip or consume
            if (own)
                cnt_q <= cnt_q + 1'b1;
        end
    end

    // ==============================
    // Engine handshake
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            valid_q <= 1'b0;
        else if (clear_i)
            valid_q <= 1'b0;
        else if (take && own)
            valid_q <= 1'b1;
        else if (valid_q && cfg_ready_i)
            valid_q <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (take && own) begin
            nip_q <= rd_data_i.eng.nip;
            arg_q <= rd_data_i.eng.arg;
        end
    end

    assign ptr_o       = ptr_q;
    assign cfg_valid_o = valid_q;
    assign cfg_nip_o   = nip_q;
    assign cfg_arg_o   = arg_q;

endmodule

/* hdl/cfg_dispatch.sv */
// Configuration dispatcher
// Runs the network FSM: reads and checks the header word, then grants
// one requesting channel at a time and routes its read pointer to the
// instruction RAM. Each inspected word costs PICK, SCAN and RESP.
`include "ccu_params.svh"

module cfg_dispatch (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          start_i,
    input  logic [`CCU_PTR_WIDTH-1:0]                     wr_ptr_i,
    input  ccu_pkg::isa_word_u                            rd_data_i,
    input  logic [`CCU_NUM_CH-1:0]                        ch_req_i,
    input  logic [`CCU_NUM_CH-1:0]                        ch_done_i,
    input  logic [`CCU_NUM_CH-1:0][`CCU_PTR_WIDTH-1:0]    ch_ptr_i,
    output logic                                          run_clear_o,
    output logic                                          run_active_o,
    output logic                                          rd_en_o,
    output logic [`CCU_PTR_WIDTH-1:0]                     rd_addr_o,
    output logic [`CCU_NUM_CH-1:0]                        grant_o,
    output logic                                          rd_valid_o,
    output logic [`CCU_LAYER_WIDTH-1:0]                   num_layer_o,
    output logic [7:0]                                    net_mode_o,
    output logic                                          net_done_o,
    output logic                                          net_busy_o
);

    ccu_pkg::disp_state_e             state_q;
    ccu_pkg::disp_state_e             state_d;
    logic [`CCU_NUM_CH-1:0]           grant_q;
    logic [`CCU_NUM_CH-1:0]           grant_d;
    logic [`CCU_PTR_WIDTH-1:0]        sel_ptr;
    logic                             hdr_ok;
    logic [`CCU_LAYER_WIDTH-1:0]      num_layer_q;
    logic [7:0]                       mode_q;

    // Header must carry its opcode and at least one layer
    assign hdr_ok = (rd_data_i.hdr.opcode == `CCU_OPC_HDR) &&
                    (rd_data_i.hdr.num_layer != '0);

    // Fixed priority, lowest index wins
    assign grant_d = ch_req_i & (~ch_req_i + 1'b1);

    // ==============================
    // Run FSM
    // ==============================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ccu_pkg::IDLE:     if (start_i) state_d = ccu_pkg::HDR_RD;
            ccu_pkg::HDR_RD:   if (wr_ptr_i != '0) state_d = ccu_pkg::HDR_WAIT;
            ccu_pkg::HDR_WAIT: state_d = hdr_ok ? ccu_pkg::PICK : ccu_pkg::DONE;
            ccu_pkg::PICK: begin
                if (&ch_done_i)
                    state_d = ccu_pkg::DONE;
                else if (|ch_req_i)
                    state_d = ccu_pkg::SCAN;
            end
            ccu_pkg::SCAN:     state_d = ccu_pkg::RESP;
            ccu_pkg::RESP:     state_d = ccu_pkg::PICK;
            default:           state_d = ccu_pkg::IDLE;     // DONE
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ccu_pkg::IDLE;
            grant_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ccu_pkg::PICK && state_d == ccu_pkg::SCAN)
                grant_q <= grant_d;     // Held through SCAN and RESP
            else if (state_q == ccu_pkg::RESP)
                grant_q <= '0;
        end
    end

    // ==============================
    // Header registers
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            num_layer_q <= '0;
            mode_q      <= '0;
        end else if (state_q == ccu_pkg::IDLE) begin
            num_layer_q <= '0;
        end else if (state_q == ccu_pkg::HDR_WAIT) begin
            mode_q <= rd_data_i.hdr.mode;
            if (hdr_ok)
                num_layer_q <= rd_data_i.hdr.num_layer;
        end
    end

    // ==============================
    // RAM read control
    // ==============================
    always_comb begin
        sel_ptr = '0;
        for (int i = 0; i < `CCU_NUM_CH; i++) begin
            if (grant_q[i])
                sel_ptr = ch_ptr_i[i];
        end
    end

    assign rd_en_o   = (state_q == ccu_pkg::HDR_RD && wr_ptr_i != '0) ||
                       (state_q == ccu_pkg::SCAN);
    assign rd_addr_o = (state_q == ccu_pkg::SCAN) ? sel_ptr : '0;  // Header at 0

    assign grant_o      = grant_q;
    assign rd_valid_o   = (state_q == ccu_pkg::RESP);
    assign run_clear_o  = (state_q == ccu_pkg::IDLE);
    assign run_active_o = (state_q != ccu_pkg::IDLE) && (state_q != ccu_pkg::DONE);
    assign num_layer_o  = num_layer_q;
    assign net_mode_o   = mode_q;
    assign net_done_o   = (state_q == ccu_pkg::DONE);
    assign net_busy_o   = (state_q != ccu_pkg::IDLE);

endmodule

/* hdl/isa_loader.sv */
// Instruction loader
// Holds one 128-bit input beat and writes it into the instruction RAM
// as two 64-bit words, low half first. Free space is tracked against
// the channel read pointer that trails the write pointer most.
`include "ccu_params.svh"

module isa_loader (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          run_clear_i,
    input  logic                                          run_active_i,
    input  logic [`CCU_IN_WIDTH-1:0]                      in_data_i,
    input  logic                                          in_valid_i,
    input  logic                                          rd_en_i,
    input  logic [`CCU_PTR_WIDTH-1:0]                     rd_addr_i,
    input  logic [`CCU_NUM_CH-1:0][`CCU_PTR_WIDTH-1:0]    ch_ptr_i,
    output logic                                          in_ready_o,
    output logic [`CCU_PTR_WIDTH-1:0]                     wr_ptr_o,
    output ccu_pkg::isa_word_u                            rd_data_o
);

    logic [`CCU_IN_WIDTH-1:0]   beat_q;
    logic                       hold_valid_q;   // Splitter holds a beat
    logic                       half_q;         // High word is next
    logic [`CCU_PTR_WIDTH-1:0]  wr_ptr_q;
    logic [`CCU_PTR_WIDTH-1:0]  max_dist;
    logic                       full;
    logic                       wr_en;
    logic [`CCU_WORD_WIDTH-1:0] wr_word;

    logic [`CCU_WORD_WIDTH-1:0] isa_ram [`CCU_ISA_DEPTH];
    ccu_pkg::isa_word_u         rd_data_q;

    // ==============================
    // Beat splitter
    // ==============================
    assign in_ready_o = run_active_i & ~hold_valid_q;
    assign wr_en      = hold_valid_q & ~full;
    assign wr_word    = half_q ? beat_q[`CCU_IN_WIDTH-1:`CCU_WORD_WIDTH]
                               : beat_q[`CCU_WORD_WIDTH-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid_q <= 1'b0;
            half_q       <= 1'b0;
        end else if (run_clear_i) begin
            hold_valid_q <= 1'b0;
            half_q       <= 1'b0;
        end else if (in_valid_i && in_ready_o) begin
            hold_valid_q <= 1'b1;
            half_q       <= 1'b0;
        end else if (wr_en) begin
            if (half_q)
                hold_valid_q <= 1'b0;   // Both halves stored
            half_q <= ~half_q;
        end
    end

    // Payload only, qualified by hold_valid_q
    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o)
            beat_q <= in_data_i;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wr_ptr_q <= '0;
        else if (run_clear_i)
            wr_ptr_q <= '0;
        else if (wr_en)
            wr_ptr_q <= wr_ptr_q + 1'b1;
    end

    assign wr_ptr_o = wr_ptr_q;

    // ==============================
    // Free space
    // ==============================
    // Largest distance behind the write pointer, modulo 32
    always_comb begin
        max_dist = '0;
        for (int i = 0; i < `CCU_NUM_CH; i++) begin
            if (wr_ptr_q - ch_ptr_i[i] > max_dist)
                max_dist = wr_ptr_q - ch_ptr_i[i];
        end
    end

    assign full = (max_dist == `CCU_ISA_DEPTH);

    // ==============================
    // Instruction RAM
    // ==============================
    always_ff @(posedge clk) begin
        if (wr_en)
            isa_ram[wr_ptr_q[`CCU_PTR_WIDTH-2:0]] <= wr_word;
        if (rd_en_i)
            rd_data_q <= isa_ram[rd_addr_i[`CCU_PTR_WIDTH-2:0]]; // One cycle latency
    end

    assign rd_data_o = rd_data_q;

endmodule

/* hdl/ccu_pkg.sv */
// CCU package
// Instruction word views and the dispatcher state type
`include "ccu_params.svh"

package ccu_pkg;

    // ==============================
    // Instruction word, two views
    // ==============================

    // Network header, first word of a stream
    typedef struct packed {
        logic [`CCU_WORD_WIDTH-`CCU_LAYER_WIDTH-17:0] reserved;
        logic [7:0]                                    mode;
        logic [`CCU_LAYER_WIDTH-1:0]                   num_layer;
        logic [7:0]                                    opcode;     // Low byte
    } hdr_word_s;

    // One engine configuration
    typedef struct packed {
        logic [`CCU_ARG_WIDTH-1:0] arg;
        logic [`CCU_NIP_WIDTH-1:0] nip;
        logic [7:0]                opcode;
    } eng_word_s;

    // Same RAM word, decoded by dispatcher or by a channel
    typedef union packed {
        hdr_word_s hdr;
        eng_word_s eng;
    } isa_word_u;

    // ==============================
    // Dispatcher FSM
    // ==============================
    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        HDR_RD   = 3'd1,    // Wait for word 0, then read it
        HDR_WAIT = 3'd2,    // Header data on RAM output
        PICK     = 3'd3,
        SCAN     = 3'd4,
        RESP     = 3'd5,
        DONE     = 3'd6
    } disp_state_e;

endpackage

/* hdl/ccu_params.svh */
// CCU parameters
// Widths, depths, channel count and opcodes shared by the
// configuration control unit and its testbench
`ifndef CCU_PARAMS_SVH
`define CCU_PARAMS_SVH

// ==============================
// Datapath widths
// ==============================
`define CCU_IN_WIDTH      128     // Input beat, two words
`define CCU_WORD_WIDTH    64      // One instruction word
`define CCU_LAYER_WIDTH   16
`define CCU_NIP_WIDTH     16      // Input point count
`define CCU_ARG_WIDTH     40

// ==============================
// Instruction RAM and channels
// ==============================
`define CCU_ISA_DEPTH     16
`define CCU_PTR_WIDTH     5       // RAM index plus wrap bit
`define CCU_NUM_CH        4

// Opcodes, channel i owns base plus i
`define CCU_OPC_HDR       8'h80
`define CCU_OPC_ENG_BASE  8'h81

`endif
